/* hdl/tile_pkg.sv */
package tile_pkg;

  // Data path widths.
  localparam int addr_width_gp      = 16;
  localparam int word_width_gp      = 32;
  localparam int block_width_gp     = 128;
  localparam int words_per_block_gp = block_width_gp / word_width_gp;
  localparam int tag_width_gp       = 4;

  // Address map. Everything below dram_base_gp is local.
  localparam logic [addr_width_gp-1:0] dram_base_gp = 16'h8000;

  localparam int dev_lsb_gp   = 12;
  localparam int dev_width_gp = 3;

  localparam logic [dev_width_gp-1:0] cfg_dev_gp   = 3'd1;
  localparam logic [dev_width_gp-1:0] store_dev_gp = 3'd2;

  typedef enum logic {
    e_read  = 1'b0,
    e_write = 1'b1
  } msg_type_e;

  // 1 + 16 + 4 = 21 bits.
  typedef struct packed {
    msg_type_e                 msg_type;
    logic [addr_width_gp-1:0]  addr;
    logic [tag_width_gp-1:0]   tag;
  } mem_header_t;

  // Device side message, 53 bits.
  typedef struct packed {
    mem_header_t               header;
    logic [word_width_gp-1:0]  data;
  } word_msg_t;

  // Port side message, 149 bits.
  typedef struct packed {
    mem_header_t               header;
    logic [block_width_gp-1:0] data;
  } block_msg_t;

  // Command destination picked by the decoder.
  typedef enum logic [1:0] {
    e_store    = 2'd0,
    e_cfg      = 2'd1,
    e_loopback = 2'd2
  } target_e;

endpackage

/* hdl/msg_slot.sv */
`timescale 1ns/1ns

module msg_slot #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,

  input  payload_t data_i,
  input  logic     v_i,
  output logic     ready_o,

  output payload_t data_o,
  output logic     v_o,
  input  logic     yumi_i
);

  payload_t data_r;
  logic     v_r;
  logic     load_li;

  // Free when empty, or when the held message leaves this cycle.
  assign ready_o = ~v_r | yumi_i;
  assign load_li = v_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
    end else if (load_li) begin
      v_r <= 1'b1;
    end else if (yumi_i) begin
      v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_li) data_r <= data_i;
  end

  assign data_o = data_r;
  assign v_o    = v_r;

  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o);

endmodule

/* hdl/mem_cmd_dispatch.sv */
`timescale 1ns/1ns

module mem_cmd_dispatch (
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  tile_pkg::block_msg_t   mem_cmd_i,
  input  logic                   mem_cmd_v_i,
  output logic                   mem_cmd_ready_o,

  output tile_pkg::word_msg_t    dev_cmd_o,
  output logic                   cfg_v_o,
  input  logic                   cfg_ready_i,
  output logic                   store_v_o,
  input  logic                   store_ready_i,

  output tile_pkg::word_msg_t    lb_resp_o,
  output logic                   lb_v_o,
  input  logic                   lb_yumi_i
);

  logic                              local_li;
  logic [tile_pkg::dev_width_gp-1:0] dev_li;
  tile_pkg::target_e                 target_li;
  logic                              accept_li;
  logic                              lb_v_li;
  logic                              lb_ready_lo;
  tile_pkg::word_msg_t               lb_data_li;

  assign local_li = (mem_cmd_i.header.addr < tile_pkg::dram_base_gp);
  assign dev_li   = mem_cmd_i.header.addr[tile_pkg::dev_lsb_gp+:tile_pkg::dev_width_gp];

  always_comb begin
    if (!local_li || (dev_li == tile_pkg::store_dev_gp)) target_li = tile_pkg::e_store;
    else if (dev_li == tile_pkg::cfg_dev_gp)             target_li = tile_pkg::e_cfg;
    else                                                 target_li = tile_pkg::e_loopback;
  end

  // Only take a command when every device could, so no device loads a duplicate.
  assign mem_cmd_ready_o = cfg_ready_i & store_ready_i & lb_ready_lo;
  assign accept_li       = mem_cmd_v_i & mem_cmd_ready_o;

  assign cfg_v_o   = accept_li & (target_li == tile_pkg::e_cfg);
  assign store_v_o = accept_li & (target_li == tile_pkg::e_store);
  assign lb_v_li   = accept_li & (target_li == tile_pkg::e_loopback);

  assign dev_cmd_o  = '{header: mem_cmd_i.header,
                        data: mem_cmd_i.data[0+:tile_pkg::word_width_gp]};
  assign lb_data_li = '{header: mem_cmd_i.header, data: '0}; // Unclaimed address reads as zero.

  msg_slot #(.payload_t(tile_pkg::word_msg_t)) lb_slot (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (lb_data_li),
    .v_i    (lb_v_li),
    .ready_o(lb_ready_lo),
    .data_o (lb_resp_o),
    .v_o    (lb_v_o),
    .yumi_i (lb_yumi_i)
  );

endmodule

/* hdl/cfg_regs.sv */
`timescale 1ns/1ns

module cfg_regs #(
  parameter int num_regs_p = 4
) (
  input  logic                               clk_i,
  input  logic                               reset_i,

  input  tile_pkg::word_msg_t                cmd_i,
  input  logic                               v_i,
  output logic                               ready_o,

  input  logic [tile_pkg::word_width_gp-1:0] did_i,

  output tile_pkg::word_msg_t                resp_o,
  output logic                               resp_v_o,
  input  logic                               resp_yumi_i
);

  localparam int idx_width_lp = (num_regs_p > 1) ? $clog2(num_regs_p) : 1;

  logic [tile_pkg::word_width_gp-1:0] regs_r [1:num_regs_p-1];
  logic [idx_width_lp-1:0]            idx_li;
  logic [tile_pkg::word_width_gp-1:0] rdata_li;
  logic                               load_li;
  logic                               is_write_li;
  tile_pkg::word_msg_t                resp_li;

  // Word index within the block.
  assign idx_li      = idx_width_lp'((cmd_i.header.addr >> 2) % num_regs_p);
  assign is_write_li = (cmd_i.header.msg_type == tile_pkg::e_write);
  assign load_li     = v_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < num_regs_p; i++) begin
        regs_r[i] <= '0;
      end
    end else if (load_li && is_write_li && (idx_li != '0)) begin
      regs_r[idx_li] <= cmd_i.data;
    end
  end

  // Register 0 is the device id, read only.
  always_comb begin
    if (idx_li == '0) rdata_li = did_i;
    else              rdata_li = regs_r[idx_li];
  end

  assign resp_li = '{header: cmd_i.header,
                     data: is_write_li ? '0 : rdata_li};

  msg_slot #(.payload_t(tile_pkg::word_msg_t)) resp_slot (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (resp_li),
    .v_i    (v_i),
    .ready_o(ready_o),
    .data_o (resp_o),
    .v_o    (resp_v_o),
    .yumi_i (resp_yumi_i)
  );

endmodule

/* hdl/backing_store.sv */
`timescale 1ns/1ns

module backing_store #(
  parameter int depth_p = 64
) (
  input  logic                clk_i,
  input  logic                reset_i,

  input  tile_pkg::word_msg_t cmd_i,
  input  logic                v_i,
  output logic                ready_o,

  output tile_pkg::word_msg_t resp_o,
  output logic                resp_v_o,
  input  logic                resp_yumi_i
);

  localparam int idx_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;

  logic [tile_pkg::word_width_gp-1:0] mem_r [depth_p];
  logic [idx_width_lp-1:0]            idx_li;
  logic                               is_write_li;
  logic                               load_li;
  tile_pkg::word_msg_t                resp_li;

  // Byte address to word index, wrapping over the store.
  assign idx_li      = idx_width_lp'((cmd_i.header.addr >> 2) % depth_p);
  assign is_write_li = (cmd_i.header.msg_type == tile_pkg::e_write);
  assign load_li     = v_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (load_li && is_write_li) begin
      mem_r[idx_li] <= cmd_i.data;
    end
  end

  // Writes are acknowledged with zero data.
  assign resp_li = '{header: cmd_i.header,
                     data: is_write_li ? '0 : mem_r[idx_li]};

  msg_slot #(.payload_t(tile_pkg::word_msg_t)) resp_slot (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (resp_li),
    .v_i    (v_i),
    .ready_o(ready_o),
    .data_o (resp_o),
    .v_o    (resp_v_o),
    .yumi_i (resp_yumi_i)
  );

endmodule

/* hdl/resp_arbiter.sv */
`timescale 1ns/1ns

module resp_arbiter (
  input  logic                 clk_i,
  input  logic                 reset_i,

  input  tile_pkg::word_msg_t  store_resp_i,
  input  logic                 store_v_i,
  output logic                 store_yumi_o,

  input  tile_pkg::word_msg_t  cfg_resp_i,
  input  logic                 cfg_v_i,
  output logic                 cfg_yumi_o,

  input  tile_pkg::word_msg_t  lb_resp_i,
  input  logic                 lb_v_i,
  output logic                 lb_yumi_o,

  output tile_pkg::block_msg_t mem_resp_o,
  output logic                 mem_resp_v_o,
  input  logic                 mem_resp_yumi_i
);

  logic                 store_grant_li;
  logic                 cfg_grant_li;
  logic                 lb_grant_li;
  tile_pkg::word_msg_t  sel_li;
  tile_pkg::block_msg_t block_li;
  logic                 slot_v_li;
  logic                 slot_ready_lo;
  logic                 take_li;
  logic [2:0]           pending_li;

  // Store wins, then cfg, then loopback.
  assign store_grant_li = store_v_i;
  assign cfg_grant_li   = cfg_v_i & ~store_v_i;
  assign lb_grant_li    = lb_v_i & ~store_v_i & ~cfg_v_i;

  always_comb begin
    if (store_grant_li)    sel_li = store_resp_i;
    else if (cfg_grant_li) sel_li = cfg_resp_i;
    else                   sel_li = lb_resp_i;
  end

  assign block_li = '{header: sel_li.header,
                      data: {tile_pkg::words_per_block_gp{sel_li.data}}};

  // Load only into an empty slot, never alongside its own yumi.
  assign slot_v_li = (store_v_i | cfg_v_i | lb_v_i) & ~mem_resp_v_o;
  assign take_li   = slot_v_li & slot_ready_lo;

  assign store_yumi_o = take_li & store_grant_li;
  assign cfg_yumi_o   = take_li & cfg_grant_li;
  assign lb_yumi_o    = take_li & lb_grant_li;

  // Offered but not taken this cycle.
  assign pending_li = {store_v_i, cfg_v_i, lb_v_i} & ~{store_yumi_o, cfg_yumi_o, lb_yumi_o};

  msg_slot #(.payload_t(tile_pkg::block_msg_t)) out_slot (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (block_li),
    .v_i    (slot_v_li),
    .ready_o(slot_ready_lo),
    .data_o (mem_resp_o),
    .v_o    (mem_resp_v_o),
    .yumi_i (mem_resp_yumi_i)
  );

  // A device keeps offering its response until it is taken.
  resp_held: assert property (@(posedge clk_i) disable iff (reset_i)
    ($past(pending_li) & ~{store_v_i, cfg_v_i, lb_v_i}) == '0);

endmodule

/* hdl/l2e_tile.sv */
`timescale 1ns/1ns

module l2e_tile #(
  parameter int store_depth_p = 64,
  parameter int cfg_regs_p    = 4
) (
  input  logic                               clk_i,
  input  logic                               reset_i,

  input  logic [tile_pkg::word_width_gp-1:0] did_i,

  input  tile_pkg::block_msg_t               mem_cmd_i,
  input  logic                               mem_cmd_v_i,
  output logic                               mem_cmd_ready_o,

  output tile_pkg::block_msg_t               mem_resp_o,
  output logic                               mem_resp_v_o,
  input  logic                               mem_resp_yumi_i
);

  // Decode to execute.
  tile_pkg::word_msg_t dev_cmd_lo;
  logic                cfg_v_lo, cfg_ready_lo;
  logic                store_v_lo, store_ready_lo;

  // Execute to result.
  tile_pkg::word_msg_t cfg_resp_lo, store_resp_lo, lb_resp_lo;
  logic                cfg_resp_v_lo, store_resp_v_lo, lb_v_lo;
  logic                cfg_yumi_li, store_yumi_li, lb_yumi_li;

  mem_cmd_dispatch dispatch (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .mem_cmd_i      (mem_cmd_i),
    .mem_cmd_v_i    (mem_cmd_v_i),
    .mem_cmd_ready_o(mem_cmd_ready_o),
    .dev_cmd_o      (dev_cmd_lo),
    .cfg_v_o        (cfg_v_lo),
    .cfg_ready_i    (cfg_ready_lo),
    .store_v_o      (store_v_lo),
    .store_ready_i  (store_ready_lo),
    .lb_resp_o      (lb_resp_lo),
    .lb_v_o         (lb_v_lo),
    .lb_yumi_i      (lb_yumi_li)
  );

  cfg_regs #(.num_regs_p(cfg_regs_p)) cfg (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cmd_i      (dev_cmd_lo),
    .v_i        (cfg_v_lo),
    .ready_o    (cfg_ready_lo),
    .did_i      (did_i),
    .resp_o     (cfg_resp_lo),
    .resp_v_o   (cfg_resp_v_lo),
    .resp_yumi_i(cfg_yumi_li)
  );

  backing_store #(.depth_p(store_depth_p)) store (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cmd_i      (dev_cmd_lo),
    .v_i        (store_v_lo),
    .ready_o    (store_ready_lo),
    .resp_o     (store_resp_lo),
    .resp_v_o   (store_resp_v_lo),
    .resp_yumi_i(store_yumi_li)
  );

  resp_arbiter arb (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .store_resp_i   (store_resp_lo),
    .store_v_i      (store_resp_v_lo),
    .store_yumi_o   (store_yumi_li),
    .cfg_resp_i     (cfg_resp_lo),
    .cfg_v_i        (cfg_resp_v_lo),
    .cfg_yumi_o     (cfg_yumi_li),
    .lb_resp_i      (lb_resp_lo),
    .lb_v_i         (lb_v_lo),
    .lb_yumi_o      (lb_yumi_li),
    .mem_resp_o     (mem_resp_o),
    .mem_resp_v_o   (mem_resp_v_o),
    .mem_resp_yumi_i(mem_resp_yumi_i)
  );

endmodule

/* bench/tile_tests.svh */
// Idle port after reset, then a store read on an empty pipeline.
task automatic test_reset_latency();
  int cycles;
  checks++;
  assert (!mem_resp_v && mem_cmd_ready) else begin
    errors++;
    $display("reset_latency: port not idle after reset (resp_v %b, cmd_ready %b)",
             mem_resp_v, mem_cmd_ready);
  end
  send_cmd(tile_pkg::e_read, 16'h8040, 4'h1, '0);
  cycles = 0;
  do begin
    @(posedge clk_i);
    cycles++;
  end while (!mem_resp_v);
  checks++;
  assert (cycles == 2) else begin
    errors++;
    $display("mismatch reset_latency: expected 2 cycles, actual %0d cycles", cycles);
  end
  recv_check("reset_latency");
endtask

task automatic test_store();
  transact("store_write", tile_pkg::e_write, 16'ha0f4, 4'h2,
           {$urandom(), $urandom(), $urandom(), 32'hcafe_f00d});
  transact("store_read", tile_pkg::e_read, 16'ha0f4, 4'h3, '0);
endtask

task automatic test_cfg();
  transact("cfg_did", tile_pkg::e_read, 16'h1000, 4'h4, '0);
  transact("cfg_did_write", tile_pkg::e_write, 16'h1000, 4'h5, {96'h0, 32'hdead_beef});
  transact("cfg_did_again", tile_pkg::e_read, 16'h1000, 4'h6, '0);
  transact("cfg_w1", tile_pkg::e_write, 16'h1004, 4'h7, {$urandom(), $urandom(), $urandom(), 32'h1111_0001});
  transact("cfg_w2", tile_pkg::e_write, 16'h1008, 4'h8, {96'h0, 32'h2222_0002});
  transact("cfg_w3", tile_pkg::e_write, 16'h101c, 4'h9, {96'h0, 32'h3333_0003}); // Aliases reg 3.
  transact("cfg_r1", tile_pkg::e_read, 16'h1004, 4'ha, '0);
  transact("cfg_r2", tile_pkg::e_read, 16'h1008, 4'hb, '0);
  transact("cfg_r3", tile_pkg::e_read, 16'h100c, 4'hc, '0);
endtask

task automatic test_loopback();
  transact("loopback", tile_pkg::e_write, 16'h3abc, 4'hd, {4{32'h5a5a_a5a5}});
endtask

// No command is taken while a device slot holds an unread response,
// so the three responses leave in command order.
task automatic test_backpressure();
  fork
    begin
      send_cmd(tile_pkg::e_read, 16'h3004, 4'h5, '0);
      send_cmd(tile_pkg::e_read, 16'h1008, 4'h6, '0);
      send_cmd(tile_pkg::e_read, 16'ha0f4, 4'h7, '0);
    end
    begin
      repeat (6) @(posedge clk_i);
      checks++;
      assert (mem_resp_v && !mem_cmd_ready) else begin
        errors++;
        $display("backpressure: command port kept accepting while the response was held");
      end
      repeat (3) recv_check("backpressure");
    end
  join
endtask

task automatic test_random();
  tile_pkg::msg_type_e t;
  logic [15:0]         addr;
  for (int n = 0; n < 40; n++) begin
    addr = 16'($urandom()) & 16'hff1f; // Eight words, aliased through the upper bits.
    if ($urandom_range(3) == 0) addr[15:12] = {1'b0, tile_pkg::store_dev_gp};
    else addr[15] = 1'b1;
    if ($urandom_range(1) == 1 && store_known[store_index(addr)]) t = tile_pkg::e_read;
    else t = tile_pkg::e_write;
    transact($sformatf("random_%0d", n), t, addr, 4'(n),
             {$urandom(), $urandom(), $urandom(), $urandom()});
  end
endtask

/* bench/tile_tb.sv */
`timescale 1ns/1ns

module tile_tb;

  localparam int reset_cycles   = 16;
  localparam int num_cmds       = 56; // Commands issued over all tests.
  localparam int timeout_cycles = num_cmds * 10 + reset_cycles;
  localparam int store_depth    = 64;
  localparam int cfg_regs       = 4;
  localparam int word_w         = tile_pkg::word_width_gp;
  localparam int block_w        = tile_pkg::block_width_gp;

  logic                 clk_i = 1'b0;
  logic                 reset_i;
  logic [word_w-1:0]    did;
  tile_pkg::block_msg_t mem_cmd;
  logic                 mem_cmd_v;
  logic                 mem_cmd_ready;
  tile_pkg::block_msg_t mem_resp;
  logic                 mem_resp_v;
  logic                 mem_resp_yumi;

  int errors      = 0;
  int checks      = 0;
  int cycle_count = 0;

  // Reference model of the devices, plus expected responses in order.
  logic [word_w-1:0]    store_model [store_depth];
  bit                   store_known [store_depth];
  logic [word_w-1:0]    cfg_model   [cfg_regs];
  tile_pkg::block_msg_t exp_q[$];
  bit                   known_q[$];

  always #2 clk_i = ~clk_i;

  l2e_tile #(
    .store_depth_p(store_depth),
    .cfg_regs_p   (cfg_regs)
  ) dut_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .did_i          (did),
    .mem_cmd_i      (mem_cmd),
    .mem_cmd_v_i    (mem_cmd_v),
    .mem_cmd_ready_o(mem_cmd_ready),
    .mem_resp_o     (mem_resp),
    .mem_resp_v_o   (mem_resp_v),
    .mem_resp_yumi_i(mem_resp_yumi)
  );

  function automatic tile_pkg::target_e target_of(logic [15:0] addr);
    logic [tile_pkg::dev_width_gp-1:0] dev;
    dev = addr[tile_pkg::dev_lsb_gp +: tile_pkg::dev_width_gp];
    if (addr >= tile_pkg::dram_base_gp || dev == tile_pkg::store_dev_gp) return tile_pkg::e_store;
    if (dev == tile_pkg::cfg_dev_gp) return tile_pkg::e_cfg;
    return tile_pkg::e_loopback;
  endfunction

  function automatic int store_index(logic [15:0] addr);
    return (addr / 4) % store_depth;
  endfunction

  // Expected response word. Writes update the model here.
  function automatic logic [word_w-1:0] predict(tile_pkg::block_msg_t cmd, output bit known);
    logic [word_w-1:0] word;
    int                idx;
    word  = cmd.data[word_w-1:0];
    known = 1'b1;
    case (target_of(cmd.header.addr))
      tile_pkg::e_store: begin
        idx = store_index(cmd.header.addr);
        if (cmd.header.msg_type == tile_pkg::e_write) begin
          store_model[idx] = word;
          store_known[idx] = 1'b1;
          return '0;
        end
        known = store_known[idx]; // Unwritten words are undefined.
        return store_model[idx];
      end
      tile_pkg::e_cfg: begin
        idx = (cmd.header.addr / 4) % cfg_regs;
        if (cmd.header.msg_type == tile_pkg::e_write) begin
          if (idx != 0) cfg_model[idx] = word;
          return '0;
        end
        return (idx == 0) ? did : cfg_model[idx];
      end
      default: return '0;
    endcase
  endfunction

  function automatic tile_pkg::block_msg_t widen(tile_pkg::mem_header_t hdr,
                                                 logic [word_w-1:0] word);
    tile_pkg::block_msg_t msg;
    msg.header = hdr;
    for (int i = 0; i < tile_pkg::words_per_block_gp; i++) msg.data[i*word_w +: word_w] = word;
    return msg;
  endfunction

  task automatic check_value(string name, string field, logic [block_w-1:0] exp_val,
                             logic [block_w-1:0] act_val);
    checks++;
    assert (act_val === exp_val) else begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", name, field, exp_val, act_val);
    end
  endtask

  task automatic send_cmd(tile_pkg::msg_type_e t, logic [15:0] addr, logic [3:0] tag,
                          logic [block_w-1:0] data);
    tile_pkg::block_msg_t cmd;
    logic [word_w-1:0]    word;
    bit                   known;
    cmd.header.msg_type = t;
    cmd.header.addr     = addr;
    cmd.header.tag      = tag;
    cmd.data            = data;
    word = predict(cmd, known);
    exp_q.push_back(widen(cmd.header, word));
    known_q.push_back(known);
    mem_cmd   <= cmd;
    mem_cmd_v <= 1'b1;
    @(posedge clk_i);
    while (!mem_cmd_ready) @(posedge clk_i);
    mem_cmd_v <= 1'b0;
  endtask

  task automatic recv_check(string name);
    tile_pkg::block_msg_t exp_msg;
    tile_pkg::block_msg_t act_msg;
    bit                   known;
    @(posedge clk_i);
    while (!mem_resp_v) @(posedge clk_i);
    act_msg = mem_resp;
    mem_resp_yumi <= 1'b1;
    @(posedge clk_i);
    mem_resp_yumi <= 1'b0;
    exp_msg = exp_q.pop_front();
    known   = known_q.pop_front();
    check_value(name, "header", block_w'(exp_msg.header), block_w'(act_msg.header));
    if (known) check_value(name, "data", exp_msg.data, act_msg.data);
  endtask

  task automatic transact(string name, tile_pkg::msg_type_e t, logic [15:0] addr,
                          logic [3:0] tag, logic [block_w-1:0] data);
    send_cmd(t, addr, tag, data);
    recv_check(name);
  endtask

  `include "tile_tests.svh"

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(87));
    foreach (cfg_model[i]) cfg_model[i] = '0;
    reset_i       <= 1'b1;
    did           <= 32'h1e2d_0007;
    mem_cmd       <= '0;
    mem_cmd_v     <= 1'b0;
    mem_resp_yumi <= 1'b0;
    repeat (reset_cycles) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    test_reset_latency();
    test_store();
    test_cfg();
    test_loopback();
    test_backpressure();
    test_random();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tile_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

SOURCES := $(wildcard hdl/*.sv bench/*.sv bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qx "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi; \
	if [ $$status -ne 0 ] || ! grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "FAIL: simulation ended without a pass line"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* src.f */
+incdir+bench
hdl/tile_pkg.sv
hdl/msg_slot.sv
hdl/mem_cmd_dispatch.sv
hdl/cfg_regs.sv
hdl/backing_store.sv
hdl/resp_arbiter.sv
hdl/l2e_tile.sv
bench/tile_tb.sv
